//--- cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int memDepth = 512;
    localparam int memAddrWidth = 9;

    // IR field positions
    localparam int opMsb = 31;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;
    localparam int cWidth = 19;  // C occupies 18:0

    typedef enum logic [4:0] {
        opLd  = 5'd0,
        opLdi = 5'd1,
        opSt  = 5'd2,
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opShr = 5'd7,
        opShl = 5'd8,
        opIn  = 5'd22,
        opOut = 5'd23
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShr,
        aluShl,
        aluIncPc
    } aluOpT;

    // One bus cycle worth of controls
    typedef struct packed {
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic marIn;
        logic mdrIn;
        logic outPortIn;
        logic incPc;
        logic pcOut;   // Bus sources, at most one per cycle
        logic zOut;
        logic mdrOut;
        logic inPortOut;
        logic cOut;
        logic read;
        logic write;
        logic gra;
        logic grb;
        logic grc;
        logic rin;
        logic rout;
        logic baOut;
        aluOpT aluOp;
    } ctrlT;

endpackage

//--- regFile.sv
`timescale 1ns/1ns
module regFile (
    input  logic clk,
    input  logic rstN,
    input  logic [3:0] ra,
    input  logic [3:0] rb,
    input  logic [3:0] rc,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic rin,
    input  logic rout,
    input  logic baOut,
    input  logic [cpuPkg::dataWidth-1:0] busIn,
    output logic [cpuPkg::dataWidth-1:0] regData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [16];
    logic [3:0] sel;

    // Select and encode from whichever field is granted
    assign sel = ({4{gra}} & ra) | ({4{grb}} & rb) | ({4{grc}} & rc);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (rin) begin
            regs[sel] <= busIn;
        end
    end

    always_comb begin
        if (baOut && sel == 4'd0) begin
            regData = '0;  // Base of R0 means absolute address
        end else if (rout || baOut) begin
            regData = regs[sel];
        end else begin
            regData = '0;
        end
    end

endmodule

//--- busMux.sv
`timescale 1ns/1ns
module busMux (
    input  logic [cpuPkg::dataWidth-1:0] regData,
    input  logic [cpuPkg::dataWidth-1:0] pcData,
    input  logic [cpuPkg::dataWidth-1:0] zData,
    input  logic [cpuPkg::dataWidth-1:0] mdrData,
    input  logic [cpuPkg::dataWidth-1:0] inPortData,
    input  logic [cpuPkg::dataWidth-1:0] cData,
    input  logic regOut,
    input  logic pcOut,
    input  logic zOut,
    input  logic mdrOut,
    input  logic inPortOut,
    input  logic cOut,
    output logic [cpuPkg::dataWidth-1:0] bus
);
    import cpuPkg::*;

    // Enables are one-hot, so an AND-OR tree needs no priority
    always_comb begin
        bus = ({dataWidth{regOut}} & regData)
            | ({dataWidth{pcOut}} & pcData)
            | ({dataWidth{zOut}} & zData)
            | ({dataWidth{mdrOut}} & mdrData)
            | ({dataWidth{inPortOut}} & inPortData)
            | ({dataWidth{cOut}} & cData);
    end

endmodule

//--- alu.sv
`timescale 1ns/1ns
module alu (
    input  cpuPkg::aluOpT aluOp,
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only the low five bits count

    // a comes from Y, b straight off the bus
    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluShr: begin
                result = a >> shamt;  // Logical, zero fill
            end
            aluShl: begin
                result = a << shamt;
            end
            aluIncPc: begin
                result = b + dataWidth'(1);  // PC sits on the bus in T0
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- memUnit.sv
`timescale 1ns/1ns
module memUnit (
    input  logic clk,
    input  logic rstN,
    input  logic marIn,
    input  logic mdrIn,
    input  logic read,
    input  logic write,
    input  logic [cpuPkg::dataWidth-1:0] busIn,
    output logic [cpuPkg::dataWidth-1:0] mdrData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] ram [memDepth];
    logic [memAddrWidth-1:0] mar;  // Upper address bits dropped
    logic [dataWidth-1:0] memData;

    // Program and data image
    initial begin
        $readmemh("ram.mem", ram);
    end

    assign memData = ram[mar];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
            mdrData <= '0;
        end else begin
            if (marIn) begin
                mar <= busIn[memAddrWidth-1:0];
            end
            if (mdrIn) begin
                mdrData <= read ? memData : busIn;
            end
        end
    end

    // Store path always goes through MDR
    always_ff @(posedge clk) begin
        if (write) begin
            ram[mar] <= mdrData;
        end
    end

endmodule

//--- datapath.sv
`timescale 1ns/1ns
module datapath (
    input  logic clk,
    input  logic rstN,
    input  cpuPkg::ctrlT ctrl,
    output cpuPkg::opcodeT opcode,
    input  logic [cpuPkg::dataWidth-1:0] inPort,
    output logic [cpuPkg::dataWidth-1:0] outPort
);
    import cpuPkg::*;

    logic [dataWidth-1:0] bus;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] ir;
    logic [dataWidth-1:0] irNext;
    logic [dataWidth-1:0] y;
    logic [dataWidth-1:0] z;
    logic [dataWidth-1:0] inPortReg;
    logic [dataWidth-1:0] regData;
    logic [dataWidth-1:0] mdrData;
    logic [dataWidth-1:0] cData;
    logic [dataWidth-1:0] aluResult;
    logic [3:0] ra;
    logic [3:0] rb;
    logic [3:0] rc;
    aluOpT aluOpSel;

    assign ra = ir[raLsb +: 4];
    assign rb = ir[rbLsb +: 4];
    assign rc = ir[rcLsb +: 4];
    assign cData = {{(dataWidth - cWidth){ir[cWidth-1]}}, ir[cWidth-1:0]};

    // Opcode of the word IR holds after this edge, so T3 can be decoded in T2
    assign irNext = ctrl.irIn ? bus : ir;
    assign opcode = opcodeT'(irNext[opMsb -: $bits(opcodeT)]);

    assign aluOpSel = ctrl.incPc ? aluIncPc : ctrl.aluOp;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            outPort <= '0;
        end else begin
            ir <= irNext;
            if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.outPortIn) begin
                outPort <= bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        inPortReg <= inPort;  // Sampled every cycle
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= aluResult;
        end
    end

    regFile uRegFile (
        .clk(clk), .rstN(rstN), .ra(ra), .rb(rb), .rc(rc),
        .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc), .rin(ctrl.rin),
        .rout(ctrl.rout), .baOut(ctrl.baOut), .busIn(bus), .regData(regData)
    );

    busMux uBusMux (
        .regData(regData), .pcData(pc), .zData(z), .mdrData(mdrData),
        .inPortData(inPortReg), .cData(cData), .regOut(ctrl.rout | ctrl.baOut),
        .pcOut(ctrl.pcOut), .zOut(ctrl.zOut), .mdrOut(ctrl.mdrOut),
        .inPortOut(ctrl.inPortOut), .cOut(ctrl.cOut), .bus(bus)
    );

    alu uAlu (.aluOp(aluOpSel), .a(y), .b(bus), .result(aluResult));

    memUnit uMemUnit (
        .clk(clk), .rstN(rstN), .marIn(ctrl.marIn), .mdrIn(ctrl.mdrIn),
        .read(ctrl.read), .write(ctrl.write), .busIn(bus), .mdrData(mdrData)
    );

endmodule

//--- ctrlSeq.sv
`timescale 1ns/1ns
module ctrlSeq (
    input  logic clk,
    input  logic rstN,
    input  logic stepReq,
    output logic stepAck,
    input  cpuPkg::opcodeT opcode,
    output cpuPkg::ctrlT ctrl
);
    import cpuPkg::*;

    typedef enum logic [3:0] {
        sIdle, sT0, sT1, sT2, sT3, sT4, sT5, sT6, sT7, sDone
    } stateT;

    stateT state;
    stateT stateNext;

    function automatic aluOpT aluFor(opcodeT op);
        case (op)
            opSub: return aluSub;
            opAnd: return aluAnd;
            opOr: return aluOr;
            opShr: return aluShr;
            opShl: return aluShl;
            default: return aluAdd;  // add and address arithmetic
        endcase
    endfunction

    // Controls for one state, applied for the whole cycle
    function automatic ctrlT decode(stateT s, opcodeT op);
        ctrlT c;
        logic memOp;
        logic ldSt;
        c = '0;
        memOp = op inside {opLd, opLdi, opSt};  // Rb + C address forms
        ldSt = op inside {opLd, opSt};
        case (s)
            sT0: begin
                c.pcOut = 1'b1;
                c.marIn = 1'b1;
                c.incPc = 1'b1;
                c.zIn = 1'b1;
            end
            sT1: begin
                c.zOut = 1'b1;
                c.pcIn = 1'b1;
                c.read = 1'b1;
                c.mdrIn = 1'b1;
            end
            sT2: begin
                c.mdrOut = 1'b1;
                c.irIn = 1'b1;
            end
            sT3: begin
                if (op == opIn) begin
                    c.inPortOut = 1'b1;
                    c.gra = 1'b1;
                    c.rin = 1'b1;
                end else if (op == opOut) begin
                    c.gra = 1'b1;
                    c.rout = 1'b1;
                    c.outPortIn = 1'b1;
                end else begin
                    c.grb = 1'b1;
                    c.baOut = memOp;
                    c.rout = !memOp;
                    c.yIn = 1'b1;
                end
            end
            sT4: begin
                c.zIn = 1'b1;
                c.aluOp = aluFor(op);
                c.cOut = memOp;  // Offset instead of Rc
                c.grc = !memOp;
                c.rout = !memOp;
            end
            sT5: begin
                c.zOut = 1'b1;
                c.marIn = ldSt;
                c.gra = !ldSt;  // ldi and ALU results land in Ra
                c.rin = !ldSt;
            end
            sT6: begin
                c.mdrIn = 1'b1;
                c.read = (op == opLd);
                c.gra = (op == opSt);
                c.rout = (op == opSt);
            end
            sT7: begin
                c.write = (op == opSt);
                c.mdrOut = (op == opLd);
                c.gra = (op == opLd);
                c.rin = (op == opLd);
            end
            default: begin
                c = '0;
            end
        endcase
        return c;
    endfunction

    always_comb begin
        stateNext = state;
        case (state)
            sIdle: stateNext = stepReq ? sT0 : sIdle;
            sT0: stateNext = sT1;
            sT1: stateNext = sT2;
            sT2: stateNext = sT3;
            sT3: stateNext = (opcode inside {opIn, opOut}) ? sDone : sT4;
            sT4: stateNext = sT5;
            sT5: stateNext = (opcode inside {opLd, opSt}) ? sT6 : sDone;
            sT6: stateNext = sT7;
            sT7: stateNext = sDone;
            sDone: stateNext = stepReq ? sDone : sIdle;  // Wait for request to drop
            default: stateNext = sIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            ctrl <= '0;
        end else begin
            state <= stateNext;
            ctrl <= decode(stateNext, opcode);  // Lines up with the state it enters
        end
    end

    assign stepAck = (state == sDone);

endmodule

//--- cpuTop.sv
`timescale 1ns/1ns
module cpuTop (
    input  logic clk,
    input  logic rstN,
    input  logic stepReq,
    output logic stepAck,
    input  logic [31:0] inPort,
    output logic [31:0] outPort
);
    import cpuPkg::*;

    ctrlT ctrl;
    opcodeT opcode;

    ctrlSeq uCtrlSeq (
        .clk(clk),
        .rstN(rstN),
        .stepReq(stepReq),
        .stepAck(stepAck),
        .opcode(opcode),
        .ctrl(ctrl)
    );

    datapath uDatapath (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .opcode(opcode),
        .inPort(inPort),
        .outPort(outPort)
    );

endmodule

//--- cpuTb.sv
`timescale 1ns/1ns
module cpuTb;

    localparam int runs = 2;
    localparam int stepsPerRun = 20;
    localparam int stepCycles = 12;   // Worst case ld/st plus hold and release
    localparam int resetCycles = 10;
    localparam int timeoutCycles = runs * (stepsPerRun * stepCycles + resetCycles + 4);

    logic clk;
    logic rstN;
    logic stepReq;
    logic stepAck;
    logic [31:0] inPort;
    logic [31:0] outPort;
    logic [31:0] lcgState = 32'h6534a446;
    int cycleCount = 0;

    cpuTop DUT (
        .clk(clk),
        .rstN(rstN),
        .stepReq(stepReq),
        .stepAck(stepAck),
        .inPort(inPort),
        .outPort(outPort)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else stopOnError($sformatf("error %s: expected %h, actual %h",
                                   name, expected, actual));
    endtask

    // Caller sits 2 ns after a rising edge
    task automatic doStep(input logic [31:0] data);
        inPort = data;
        stepReq = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!stepAck);
        @(posedge clk);
        #2;
        assert (stepAck) else stopOnError("stepAck dropped while stepReq was still high");
        stepReq = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (stepAck);
    endtask

    task automatic resetCpu();
        rstN = 1'b0;
        stepReq = 1'b0;
        inPort = '0;
        repeat (resetCycles) @(posedge clk);
        #2;
        rstN = 1'b1;
        checkValue("reset outPort", 32'h0, outPort);
        repeat (2) @(posedge clk);  // No request yet, so no ack either
        #2;
        checkValue("idle stepAck", 32'h0, {31'b0, stepAck});
    endtask

    // Operation step followed by an out of its result
    task automatic stepTwiceAndCheck(input string name, input logic [31:0] expected);
        doStep('0);
        doStep('0);
        checkValue(name, expected, outPort);
    endtask

    task automatic runProgram(input int run);
        logic [31:0] a;
        logic [31:0] b;
        string tag;
        a = nextRand();
        b = nextRand();
        tag = $sformatf("run%0d", run);
        doStep(a);  // in R1
        doStep(b);  // in R2
        stepTwiceAndCheck({tag, " add"}, a + b);
        stepTwiceAndCheck({tag, " sub"}, a - b);
        stepTwiceAndCheck({tag, " and"}, a & b);
        stepTwiceAndCheck({tag, " or"}, a | b);
        stepTwiceAndCheck({tag, " shl"}, a << b[4:0]);
        stepTwiceAndCheck({tag, " ldi"}, a + 32'h45);
        doStep('0);  // st of R3, which holds the or result
        stepTwiceAndCheck({tag, " st/ld"}, a | b);
        stepTwiceAndCheck({tag, " ld absolute"}, 32'h13243546);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            stopOnError("Timeout: the CPU did not finish the program in time");
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        stepReq = 1'b0;
        inPort = '0;
        for (int run = 1; run <= runs; run++) begin
            resetCpu();  // Second pass restarts from PC 0 with new operands
            runProgram(run);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- ram.mem
// One 32-bit hex word per instruction from address 0, two to three words per line
// Fields: opcode 31:27, ra 26:23, rb 22:19, rc 18:15 or constant C 18:0
B0800000 B1000000           // in R1, in R2
19890000 B9800000           // add R3,R1,R2 then out R3
21890000 B9800000           // sub R3,R1,R2 then out R3
29890000 B9800000           // and R3,R1,R2 then out R3
31890000 B9800000           // or R3,R1,R2 then out R3
42090000 BA000000           // shl R4,R1,R2 then out R4
0A880045 BA800000           // ldi R5,$45(R1) then out R5
11800020 03000020 BB000000  // st $20(R0),R3 then ld R6,$20(R0) then out R6
0380001F BB800000           // ld R7,$1F(R0) then out R7
@1F
13243546

//--- src.f
cpuPkg.sv
regFile.sv
busMux.sv
alu.sv
memUnit.sv
datapath.sv
ctrlSeq.sv
cpuTop.sv
cpuTb.sv
